/* n4v_sys.f */
verilog/soc_pkg.sv
verilog/cpu_bus_if.sv
verilog/bus_decode.sv
verilog/boot_rom.sv
verilog/stack_ram.sv
verilog/board_io.sv
verilog/prng.sv
verilog/audio_codec_port.sv
verilog/n4v_sys.sv
testbench/tb_n4v_sys.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and search the log for the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_n4v_sys \
	-f n4v_sys.f -Mdir obj_dir > build.log 2>&1 &&
	./obj_dir/Vtb_n4v_sys > sim.log 2>&1 ||
	{ echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "TESTBENCH PASSED" sim.log &&
	echo "Simulation passed" ||
	{ echo "Simulation failed, see sim.log"; exit 1; }

/* testbench/tb_n4v_sys.sv */
/*
 * Testbench for the n4v_sys bus subsystem
 * Clock, reset, bus tasks, reference models, assertion checks
 */
module tb_n4v_sys;

	// ==============================
	// Address map and constants
	// ==============================
	localparam logic [31:0] BOOT_B  = 32'hFFFC_0000;
	localparam logic [31:0] STACK_B = 32'hFF40_0000;
	localparam logic [31:0] LED_B   = 32'hFFDC_0600;
	localparam logic [31:0] GPIO_B  = 32'hFFDC_0700;
	localparam logic [31:0] RAND_B  = 32'hFFDC_0C00;
	localparam logic [31:0] AUD_B   = 32'hFFDC_0D00;
	localparam logic [31:0] TAPS    = 32'h8020_0003;
	// Two 256-cycle audio frames plus roughly 150 bus transfers, with margin
	localparam int TIMEOUT_CYCLES = 6000;

	logic        cpu_clk, rst;
	logic        cyc, stb, we;
	logic [1:0]  sel;
	logic [31:0] adr;
	logic [15:0] wdat, rdat;
	logic        ack;
	logic [7:0]  sw, led;
	logic [2:0]  btn;
	logic        bclk, lrclk, dac, adc;
	logic        loop_en;
	logic        collect = 1'b0;
	logic        dac_bits [64];
	logic        lr_bits [64];
	int          seed = 32'hbd44_7b41;
	int          checks = 0;
	int          errors = 0;
	int          err_mark = 0;
	int          cycles = 0;
	int          bit_cnt = 0;
	int          last_lat;

	// Serial loopback for the capture path
	assign adc = loop_en ? dac : 1'b0;

	n4v_sys i_dut (
		.cpu_clk, .rst, .cyc_i(cyc), .stb_i(stb), .we_i(we), .sel_i(sel),
		.adr_i(adr), .dat_i(wdat), .dat_o(rdat), .ack_o(ack),
		.sw_i(sw), .btn_i(btn), .led_o(led),
		.aud_bclk_o(bclk), .aud_lrclk_o(lrclk), .aud_dac_o(dac), .aud_adc_i(adc)
	);

	initial begin
		cpu_clk = 1'b0;
		forever #4 cpu_clk = ~cpu_clk;
	end

	always @(posedge cpu_clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// Data and word clock only move on the falling bit clock
	always @(posedge bclk) begin
		if (collect && bit_cnt < 64) begin
			dac_bits[bit_cnt] = dac;
			lr_bits[bit_cnt] = lrclk;
			bit_cnt = bit_cnt + 1;
		end
	end

	// ==============================
	// Bus protocol assertions
	// ==============================
	ack_pulse: assert property (@(posedge cpu_clk) disable iff (rst) ack |=> !ack)
		else begin
			errors++;
			$display("Protocol error at %0t: ack stayed high for two cycles", $time);
		end

	ack_needs_stb: assert property (@(posedge cpu_clk) disable iff (rst) !stb |=> !ack)
		else begin
			errors++;
			$display("Protocol error at %0t: ack without a strobe", $time);
		end

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("Fail at %0t: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic finish_test(input string name);
		$display("Test %s done, %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic out;
		out = s[0];
		s = s >> 1;
		if (out)
			s = s ^ TAPS;
		return s;
	endfunction

	// Expected ROM word from the vector and table layout
	function automatic logic [15:0] boot_expect(input int wa);
		logic [31:0] ssp, pc;
		ssp = 32'hFF40_1000;
		pc  = 32'hFFFC_0010;
		case (wa)
			0: return ssp[31:16];
			1: return ssp[15:0];
			2: return pc[31:16];
			3: return pc[15:0];
			default: return (wa >= 8 && wa <= 19) ? 16'(16'h4E71 + wa) : 16'h0000;
		endcase
	endfunction

	// ==============================
	// Bus tasks
	// ==============================
	// Called and returns one time unit after a rising edge
	task automatic bus_cycle(input logic w, input logic [1:0] s, input logic [31:0] a,
			input logic [15:0] wd, output logic [15:0] data);
		int waited;
		waited = 0;
		cyc = 1'b1;
		stb = 1'b1;
		we = w;
		sel = s;
		adr = a;
		wdat = wd;
		@(negedge cpu_clk);
		while (ack !== 1'b1) begin
			waited++;
			@(negedge cpu_clk);
		end
		data = rdat;
		last_lat = waited;
		@(posedge cpu_clk);
		#1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		@(negedge cpu_clk);
		check_value("ack gone after the transfer", 32'(ack), 32'd0);
		@(posedge cpu_clk);
		#1;
	endtask

	task automatic bus_write(input logic [31:0] a, input logic [1:0] s,
			input logic [15:0] d);
		logic [15:0] ignored;
		bus_cycle(1'b1, s, a, d, ignored);
	endtask

	task automatic bus_read(input logic [31:0] a, output logic [15:0] d);
		bus_cycle(1'b0, 2'b11, a, 16'h0000, d);
	endtask

	task automatic show_button(input logic [2:0] b, input logic [7:0] exp);
		btn = b;
		@(negedge cpu_clk);
		check_value("button display", 32'(led), 32'(exp));
		@(posedge cpu_clk);
		#1;
	endtask

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		logic [31:0] r, s, model;
		logic [15:0] d, left, right;
		logic [15:0] ram_model [16];
		logic [63:0] got_dac, got_lr;
		int k;
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		sel = 2'b00;
		adr = 32'd0;
		wdat = 16'h0000;
		sw = 8'h00;
		btn = 3'b000;
		loop_en = 1'b0;
		repeat (10) @(posedge cpu_clk);
		#1;
		rst = 1'b0;

		// Reset state, then latency per region
		check_value("ack after reset", 32'(ack), 32'd0);
		check_value("led after reset", 32'(led), 32'd0);
		check_value("audio pins after reset", {29'd0, bclk, lrclk, dac}, 32'd0);
		bus_read(BOOT_B, d);
		check_value("boot latency", last_lat, 1);
		bus_read(STACK_B, d);
		check_value("stack latency", last_lat, 3);
		bus_read(LED_B, d);
		check_value("board io latency", last_lat, 1);
		bus_read(RAND_B, d);
		check_value("prng latency", last_lat, 1);
		bus_read(AUD_B, d);
		check_value("audio latency", last_lat, 1);
		r = next_random();
		bus_read({4'h1, r[27:0]}, d);
		check_value("unmapped latency", last_lat, 1);
		check_value("unmapped read data", 32'(d), 32'd0);
		bus_write({4'h2, r[27:0]}, 2'b11, r[15:0]);
		check_value("unmapped write latency", last_lat, 1);
		finish_test("ack_rule");

		for (int wa = 0; wa < 24; wa++) begin
			bus_read(BOOT_B + 32'(2 * wa), d);
			check_value("boot word", 32'(d), 32'(boot_expect(wa)));
		end
		// Reset fetch alias at the bottom of memory
		for (int wa = 0; wa < 4; wa++) begin
			bus_read(32'(2 * wa), d);
			check_value("boot alias", 32'(d), 32'(boot_expect(wa)));
		end
		r = next_random();
		bus_read(BOOT_B + {16'h0000, r[15:1], 1'b0}, d);
		check_value("boot random word", 32'(d), 32'(boot_expect(int'(r[15:1]))));
		k = int'(r[3:0]) % 12 + 8;
		bus_write(BOOT_B + 32'(2 * k), 2'b11, ~boot_expect(k));
		bus_read(BOOT_B + 32'(2 * k), d);
		check_value("boot after write", 32'(d), 32'(boot_expect(k)));
		finish_test("boot_rom");

		// Sixteen scattered words, filled first so the model is known
		for (int i = 0; i < 16; i++) begin
			r = next_random();
			ram_model[i] = r[15:0];
			bus_write(STACK_B + 32'(i * 122), 2'b11, r[15:0]);
		end
		for (int n = 0; n < 24; n++) begin
			r = next_random();
			k = int'(r[3:0]);
			if (r[4]) begin
				bus_write(STACK_B + 32'(k * 122), r[6:5], r[31:16]);
				if (r[6])
					ram_model[k][15:8] = r[31:24];
				if (r[5])
					ram_model[k][7:0] = r[23:16];
			end else begin
				bus_read(STACK_B + 32'(k * 122), d);
				check_value("stack read", 32'(d), 32'(ram_model[k]));
			end
		end
		for (int i = 0; i < 16; i++) begin
			bus_read(STACK_B + 32'(i * 122), d);
			check_value("stack final read", 32'(d), 32'(ram_model[i]));
		end
		finish_test("stack_ram");

		r = next_random();
		bus_write(LED_B, 2'b11, {8'h00, r[7:0]});
		check_value("led register", 32'(led), 32'(r[7:0]));
		sw = r[15:8];
		bus_read(LED_B, d);
		check_value("switch read", 32'(d), {24'd0, r[15:8]});
		bus_write(GPIO_B, 2'b11, {14'd0, r[17:16]});
		bus_read(GPIO_B, d);
		check_value("gpio read back", 32'(d), {30'd0, r[17:16]});
		bus_write(GPIO_B, 2'b11, 16'h0000);
		bus_read(GPIO_B, d);
		check_value("gpio cleared", 32'(d), 32'd0);
		// Last transfer goes to a random unmapped address
		s = next_random();
		s[31:28] = 4'h3;
		bus_read(s, d);
		show_button(3'b100, s[23:16]);
		show_button(3'b010, s[15:8]);
		show_button(3'b001, s[7:0]);
		show_button(3'b111, s[23:16]);
		show_button(3'b011, s[15:8]);
		show_button(3'b000, r[7:0]);
		finish_test("board_io");

		s = next_random() | 32'd1;
		bus_write(RAND_B, 2'b11, s[31:16]);
		bus_write(RAND_B + 32'd2, 2'b11, s[15:0]);
		model = s;
		for (int i = 0; i < 8; i++) begin
			bus_read(RAND_B, d);
			check_value("prng upper half", 32'(d), 32'(model[31:16]));
			bus_read(RAND_B + 32'd2, d);
			check_value("prng lower half", 32'(d), 32'(model[15:0]));
			model = lfsr_step(model);
		end
		finish_test("prng");

		r = next_random();
		left = r[31:16];
		right = r[15:0];
		bus_write(AUD_B, 2'b11, left);
		bus_write(AUD_B + 32'd2, 2'b11, right);
		loop_en = 1'b1;
		collect = 1'b1;
		bus_write(GPIO_B, 2'b11, 16'h0003);
		while (bit_cnt < 64)
			@(posedge cpu_clk);
		#1;
		for (int i = 0; i < 64; i++) begin
			got_dac[63 - i] = dac_bits[i];
			got_lr[63 - i] = lr_bits[i];
		end
		// MSB first, then 16 zero bits in each slot
		check_value("left slot bits", got_dac[63:32], {left, 16'h0000});
		check_value("right slot bits", got_dac[31:0], {right, 16'h0000});
		check_value("word clock left", got_lr[63:32], 32'h0000_0000);
		check_value("word clock right", got_lr[31:0], 32'hFFFF_FFFF);
		bus_read(AUD_B + 32'd4, d);
		check_value("captured left sample", 32'(d), 32'(left));
		bus_write(GPIO_B, 2'b11, 16'h0000);
		@(negedge cpu_clk);
		check_value("audio pins disabled", {29'd0, bclk, lrclk, dac}, 32'd0);
		finish_test("audio");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* verilog/audio_codec_port.sv */
/*
 * Audio codec port: sample registers, bit and word clocks,
 * serial frame output and left input capture
 */
module audio_codec_port import soc_pkg::*; #(
	parameter int BCLK_DIV = 2
) (
	cpu_bus_if.slave    bus,
	input  logic        cs_i,
	input  logic        cpu_clk,
	input  logic        rst,
	output logic        ack_o,
	output logic [15:0] rdat_o,
	input  logic        en_tx_i,
	input  logic        en_rx_i,
	output logic        aud_bclk_o,
	output logic        aud_lrclk_o,
	output logic        aud_dac_o,
	input  logic        aud_adc_i
);

	localparam int DW = (BCLK_DIV > 1) ? $clog2(BCLK_DIV) : 1;
	localparam logic [DW-1:0] DIV_LAST = DW'(BCLK_DIV - 1);

	logic [15:0]   left_q;
	logic [15:0]   right_q;
	logic [15:0]   cap_q;
	logic [15:0]   adc_sr_q;
	logic          en;
	logic [DW-1:0] div_q;
	logic          bclk_q;
	logic [5:0]    bit_q;
	logic          tick, rise, fall;
	logic          data_bit;
	aud_frame_u    frame_q;

	// ==============================
	// Register interface
	// ==============================
	always_ff @(posedge cpu_clk) begin
		if (rst)
			ack_o <= 1'b0;
		else
			ack_o <= bus.cyc & bus.stb & cs_i & ~ack_o;
	end

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			left_q  <= 16'h0000;
			right_q <= 16'h0000;
		end else if (ack_o & bus.we) begin
			if (bus.adr[2:1] == 2'd0)
				left_q <= bus.wdat;
			else if (bus.adr[2:1] == 2'd1)
				right_q <= bus.wdat;
		end
	end

	always_comb begin
		case (bus.adr[2:1])
			2'd0:    rdat_o = left_q;
			2'd1:    rdat_o = right_q;
			2'd2:    rdat_o = cap_q;
			default: rdat_o = 16'h0000;
		endcase
	end

	// ==============================
	// Bit and word clocks
	// ==============================
	assign en   = en_tx_i | en_rx_i;
	assign tick = en & (div_q == DIV_LAST);
	assign rise = tick & ~bclk_q;
	assign fall = tick & bclk_q;
	// First 16 bits of each slot carry data
	assign data_bit = ~bit_q[4];

	always_ff @(posedge cpu_clk) begin
		if (rst || !en) begin
			div_q  <= '0;
			bclk_q <= 1'b0;
			bit_q  <= 6'd0;
		end else begin
			div_q <= tick ? '0 : div_q + 1'b1;
			if (tick)
				bclk_q <= ~bclk_q;
			if (fall)
				bit_q <= bit_q + 6'd1;
		end
	end

	// Reload at the start of the left slot, idle keeps it fresh
	always_ff @(posedge cpu_clk) begin
		if (!en || (fall && bit_q == 6'd63)) begin
			frame_q.half.left  <= left_q;
			frame_q.half.right <= right_q;
		end else if (fall && data_bit)
			frame_q.raw <= {frame_q.raw[30:0], 1'b0};
	end

	// Left slot input, sampled mid-bit
	always_ff @(posedge cpu_clk) begin
		if (rise && data_bit && !bit_q[5])
			adc_sr_q <= {adc_sr_q[14:0], aud_adc_i};
	end

	always_ff @(posedge cpu_clk) begin
		if (rst)
			cap_q <= 16'h0000;
		else if (fall && en_rx_i && bit_q == 6'd31)
			cap_q <= adc_sr_q;
	end

	assign aud_bclk_o  = bclk_q;
	assign aud_lrclk_o = bit_q[5];
	assign aud_dac_o   = en_tx_i & data_bit & frame_q.raw[31];

endmodule

/* verilog/board_io.sv */
/*
 * LED register, switch read, address display and codec enables
 */
module board_io import soc_pkg::*; (
	cpu_bus_if.slave    bus,
	input  logic        cs_i,
	input  logic        cpu_clk,
	input  logic        rst,
	output logic        ack_o,
	output logic [15:0] rdat_o,
	input  logic [7:0]  sw_i,
	input  logic [2:0]  btn_i,
	output logic [7:0]  led_o,
	output logic        en_tx_o,
	output logic        en_rx_o
);

	logic        is_gpio;
	logic        wr;
	logic [7:0]  led_q;
	logic [1:0]  gpio_q;
	logic [31:0] adr_q;

	assign is_gpio = bus.adr[31:4] == GPIO_BASE[31:4];
	assign wr      = ack_o & bus.we;

	always_ff @(posedge cpu_clk) begin
		if (rst)
			ack_o <= 1'b0;
		else
			ack_o <= bus.cyc & bus.stb & cs_i & ~ack_o;
	end

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			led_q  <= 8'h00;
			gpio_q <= 2'b00;
		end else if (wr) begin
			if (is_gpio)
				gpio_q <= bus.wdat[1:0];
			else if (bus.adr[3:1] == 3'd0)
				led_q <= bus.wdat[7:0];
		end
	end

	// Address of the most recent transfer, for the display
	always_ff @(posedge cpu_clk) begin
		if (bus.cyc & bus.stb)
			adr_q <= bus.adr;
	end

	assign rdat_o  = is_gpio ? {14'd0, gpio_q} : {8'h00, sw_i};
	assign en_tx_o = gpio_q[1];
	assign en_rx_o = gpio_q[0];

	assign led_o = btn_i[2] ? adr_q[23:16] :
	               btn_i[1] ? adr_q[15:8] :
	               btn_i[0] ? adr_q[7:0] :
	               led_q;

endmodule

/* verilog/boot_rom.sv */
/*
 * Boot ROM with reset vectors and start-up table
 */
module boot_rom import soc_pkg::*; (
	input  logic        cpu_clk,
	input  logic        rst,
	cpu_bus_if.slave    bus,
	input  logic        cs_i,
	output logic        ack_o,
	output logic [15:0] rdat_o
);

	// Word lookup over the 64 KiB window
	function automatic logic [15:0] rom_word(input logic [14:0] wa);
		logic [15:0] w;
		logic [3:0]  idx;
		w = 16'h0000;
		idx = 4'(wa - 15'(BOOT_TABLE_AT));
		case (wa)
			15'd0: w = BOOT_SSP[31:16];
			15'd1: w = BOOT_SSP[15:0];
			15'd2: w = BOOT_PC[31:16];
			15'd3: w = BOOT_PC[15:0];
			default: begin
				if (wa >= 15'(BOOT_TABLE_AT) && wa < 15'(BOOT_TABLE_AT + BOOT_TABLE_LEN))
					w = BOOT_TABLE[idx];
			end
		endcase
		return w;
	endfunction

	// Writes get an ack and nothing else
	always_ff @(posedge cpu_clk) begin
		if (rst)
			ack_o <= 1'b0;
		else
			ack_o <= bus.cyc & bus.stb & cs_i & ~ack_o;
	end

	always_ff @(posedge cpu_clk) begin
		if (cs_i & bus.stb)
			rdat_o <= rom_word(bus.adr[15:1]);
	end

endmodule

/* verilog/bus_decode.sv */
/*
 * Address decoder with unmapped-address acknowledge,
 * acknowledge merge and read data select
 */
module bus_decode import soc_pkg::*; (
	input  logic                  cpu_clk,
	input  logic                  rst,
	input  logic                  cyc_i,
	input  logic                  stb_i,
	input  logic                  we_i,
	input  logic [1:0]            sel_i,
	input  logic [31:0]           adr_i,
	input  logic [15:0]           dat_i,
	cpu_bus_if.master             bus,
	output logic [NUM_SLAVES-1:0] cs_o,
	input  logic [NUM_SLAVES-1:0] slv_ack_i,
	input  logic [15:0]           boot_rdat_i,
	input  logic [15:0]           stack_rdat_i,
	input  logic [15:0]           io_rdat_i,
	input  logic [15:0]           rand_rdat_i,
	input  logic [15:0]           aud_rdat_i,
	output logic [15:0]           dat_o,
	output logic                  ack_o
);

	logic nomap_ack_q;

	assign bus.cyc  = cyc_i;
	assign bus.stb  = stb_i;
	assign bus.we   = we_i;
	assign bus.sel  = sel_i;
	assign bus.adr  = adr_i;
	assign bus.wdat = dat_i;

	// ==============================
	// Address map compare
	// ==============================
	// Boot ROM also answers at bytes 0 to 7 for the reset fetch
	assign cs_o[SL_BOOT]  = (adr_i[31:16] == BOOT_BASE[31:16]) || (adr_i[31:3] == 29'd0);
	assign cs_o[SL_STACK] = adr_i[31:20] == STACK_BASE[31:20];
	assign cs_o[SL_IO]    = (adr_i[31:4] == LED_BASE[31:4]) || (adr_i[31:4] == GPIO_BASE[31:4]);
	assign cs_o[SL_RAND]  = adr_i[31:4] == RAND_BASE[31:4];
	assign cs_o[SL_AUD]   = adr_i[31:4] == AUD_BASE[31:4];

	// Nobody home, answer anyway so the CPU does not hang
	always_ff @(posedge cpu_clk) begin
		if (rst)
			nomap_ack_q <= 1'b0;
		else
			nomap_ack_q <= cyc_i & stb_i & ~(|cs_o) & ~nomap_ack_q;
	end

	assign ack_o = (|slv_ack_i) | nomap_ack_q;

	// ==============================
	// Read data select
	// ==============================
	always_comb begin
		dat_o = 16'h0000;
		if (cs_o[SL_BOOT])
			dat_o = boot_rdat_i;
		else if (cs_o[SL_STACK])
			dat_o = stack_rdat_i;
		else if (cs_o[SL_IO])
			dat_o = io_rdat_i;
		else if (cs_o[SL_RAND])
			dat_o = rand_rdat_i;
		else if (cs_o[SL_AUD])
			dat_o = aud_rdat_i;
	end

endmodule

/* verilog/cpu_bus_if.sv */
/*
 * Decoded CPU bus between the address decoder and the slaves
 */
interface cpu_bus_if;

	logic        cyc;
	logic        stb;
	logic        we;
	logic [1:0]  sel;
	logic [31:0] adr;
	logic [15:0] wdat;

	// Driven by the decoder
	modport master (
		output cyc, stb, we, sel, adr, wdat
	);

	// Seen by every peripheral
	modport slave (
		input cyc, stb, we, sel, adr, wdat
	);

endinterface

/* verilog/n4v_sys.sv */
/*
 * Bus and peripheral subsystem top level
 */
module n4v_sys import soc_pkg::*; #(
	parameter int          STACK_AW  = 10,
	parameter logic [31:0] PRNG_SEED = 32'h0000_0001,
	parameter int          BCLK_DIV  = 2
) (
	input  logic        cpu_clk,
	input  logic        rst,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [1:0]  sel_i,
	input  logic [31:0] adr_i,
	input  logic [15:0] dat_i,
	output logic [15:0] dat_o,
	output logic        ack_o,
	input  logic [7:0]  sw_i,
	input  logic [2:0]  btn_i,
	output logic [7:0]  led_o,
	output logic        aud_bclk_o,
	output logic        aud_lrclk_o,
	output logic        aud_dac_o,
	input  logic        aud_adc_i
);

	logic [NUM_SLAVES-1:0] cs;
	logic [NUM_SLAVES-1:0] slv_ack;
	logic [15:0]           boot_rdat, stack_rdat, io_rdat, rand_rdat, aud_rdat;
	logic                  en_tx, en_rx;

	cpu_bus_if bus_if ();

	bus_decode i_dec (
		.cpu_clk, .rst, .cyc_i, .stb_i, .we_i, .sel_i, .adr_i, .dat_i,
		.bus(bus_if.master), .cs_o(cs), .slv_ack_i(slv_ack),
		.boot_rdat_i(boot_rdat), .stack_rdat_i(stack_rdat), .io_rdat_i(io_rdat),
		.rand_rdat_i(rand_rdat), .aud_rdat_i(aud_rdat), .dat_o, .ack_o
	);

	boot_rom i_boot (
		.cpu_clk, .rst, .bus(bus_if.slave), .cs_i(cs[SL_BOOT]),
		.ack_o(slv_ack[SL_BOOT]), .rdat_o(boot_rdat)
	);

	stack_ram #(.STACK_AW(STACK_AW)) i_stack (
		.cpu_clk, .rst, .bus(bus_if.slave), .cs_i(cs[SL_STACK]),
		.ack_o(slv_ack[SL_STACK]), .rdat_o(stack_rdat)
	);

	board_io i_io (
		.bus(bus_if.slave), .cs_i(cs[SL_IO]), .cpu_clk, .rst,
		.ack_o(slv_ack[SL_IO]), .rdat_o(io_rdat), .sw_i, .btn_i, .led_o,
		.en_tx_o(en_tx), .en_rx_o(en_rx)
	);

	prng #(.PRNG_SEED(PRNG_SEED)) i_rand (
		.bus(bus_if.slave), .cs_i(cs[SL_RAND]), .cpu_clk, .rst,
		.ack_o(slv_ack[SL_RAND]), .rdat_o(rand_rdat)
	);

	audio_codec_port #(.BCLK_DIV(BCLK_DIV)) i_aud (
		.bus(bus_if.slave), .cs_i(cs[SL_AUD]), .cpu_clk, .rst,
		.ack_o(slv_ack[SL_AUD]), .rdat_o(aud_rdat), .en_tx_i(en_tx), .en_rx_i(en_rx),
		.aud_bclk_o, .aud_lrclk_o, .aud_dac_o, .aud_adc_i
	);

endmodule

/* verilog/prng.sv */
/*
 * 32-bit Galois LFSR, seedable, read as two halves
 */
module prng import soc_pkg::*; #(
	parameter logic [31:0] PRNG_SEED = 32'h0000_0001
) (
	cpu_bus_if.slave    bus,
	input  logic        cs_i,
	input  logic        cpu_clk,
	input  logic        rst,
	output logic        ack_o,
	output logic [15:0] rdat_o
);

	logic [31:0] state_q;
	logic [31:0] state_nx;
	logic        wr;
	logic        step;

	// Shift right, fold the taps in when a one falls out
	assign state_nx = {1'b0, state_q[31:1]} ^ (state_q[0] ? LFSR_TAPS : 32'd0);

	// Only offsets 0 and 2 are live
	assign wr   = ack_o & bus.we & (bus.adr[3:2] == 2'b00);
	assign step = ack_o & ~bus.we & (bus.adr[3:1] == 3'd1);

	always_ff @(posedge cpu_clk) begin
		if (rst)
			ack_o <= 1'b0;
		else
			ack_o <= bus.cyc & bus.stb & cs_i & ~ack_o;
	end

	// A zero seed would stick, software has to avoid it
	always_ff @(posedge cpu_clk) begin
		if (rst)
			state_q <= PRNG_SEED;
		else if (wr) begin
			if (bus.adr[1])
				state_q[15:0] <= bus.wdat;
			else
				state_q[31:16] <= bus.wdat;
		end else if (step)
			state_q <= state_nx;
	end

	assign rdat_o = bus.adr[1] ? state_q[15:0] : state_q[31:16];

endmodule

/* verilog/soc_pkg.sv */
/*
 * Address map, slave index constants, LFSR taps,
 * boot vectors and the audio frame type
 */
package soc_pkg;

	// ==============================
	// Address map
	// ==============================
	localparam logic [31:0] BOOT_BASE  = 32'hFFFC_0000;
	localparam logic [31:0] STACK_BASE = 32'hFF40_0000;
	localparam logic [31:0] LED_BASE   = 32'hFFDC_0600;
	localparam logic [31:0] GPIO_BASE  = 32'hFFDC_0700;
	localparam logic [31:0] RAND_BASE  = 32'hFFDC_0C00;
	localparam logic [31:0] AUD_BASE   = 32'hFFDC_0D00;

	// Bit positions in the select and ack vectors
	localparam int SL_BOOT    = 0;
	localparam int SL_STACK   = 1;
	localparam int SL_IO      = 2;
	localparam int SL_RAND    = 3;
	localparam int SL_AUD     = 4;
	localparam int NUM_SLAVES = 5;

	// Right-shifting Galois LFSR
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	// ==============================
	// Boot ROM contents
	// ==============================
	localparam logic [31:0] BOOT_SSP = 32'hFF40_1000;
	localparam logic [31:0] BOOT_PC  = 32'hFFFC_0010;

	// Start-up table, ROM words 8 to 19
	localparam int BOOT_TABLE_AT  = 8;
	localparam int BOOT_TABLE_LEN = 12;
	localparam logic [0:11][15:0] BOOT_TABLE = {
		16'h4E79, 16'h4E7A, 16'h4E7B, 16'h4E7C,
		16'h4E7D, 16'h4E7E, 16'h4E7F, 16'h4E80,
		16'h4E81, 16'h4E82, 16'h4E83, 16'h4E84
	};

	// Stereo frame, written as two samples and shifted as one word
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [15:0] left;
			logic [15:0] right;
		} half;
	} aud_frame_u;

endpackage

/* verilog/stack_ram.sv */
/*
 * Stack RAM, byte-lane writes, three-cycle ack
 */
module stack_ram import soc_pkg::*; #(
	parameter int STACK_AW = 10
) (
	input  logic        cpu_clk,
	input  logic        rst,
	cpu_bus_if.slave    bus,
	input  logic        cs_i,
	output logic        ack_o,
	output logic [15:0] rdat_o
);

	logic [15:0]         mem [2**STACK_AW];
	logic [STACK_AW-1:0] waddr;
	logic                act;
	logic                rdy1_q, rdy2_q, rdy3_q;

	assign waddr = bus.adr[STACK_AW:1];
	assign act   = bus.cyc & bus.stb & cs_i;

	// Wait-state chain, restarts whenever the strobe goes away
	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			rdy1_q <= 1'b0;
			rdy2_q <= 1'b0;
			rdy3_q <= 1'b0;
		end else begin
			rdy1_q <= act;
			rdy2_q <= rdy1_q & act;
			rdy3_q <= rdy2_q & act & ~ack_o;
		end
	end

	assign ack_o = rdy3_q & act;

	// Upper lane is the even byte
	always_ff @(posedge cpu_clk) begin
		if (ack_o & bus.we) begin
			if (bus.sel[1])
				mem[waddr][15:8] <= bus.wdat[15:8];
			if (bus.sel[0])
				mem[waddr][7:0] <= bus.wdat[7:0];
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (cs_i)
			rdat_o <= mem[waddr];
	end

endmodule
